// File: bench/tb_stream_rd_buf.sv
// Testbench for the pre-allocating read-stream buffer
// Random requests, a memory responder and a random consumer,
// checked against a reservation and data model

`timescale 1ns/10ps

module tb_stream_rd_buf;

    import buf_geom_pkg::*;
    import axi_rd_pkg::*;

    localparam int NUM_REQ       = 300;
    localparam int RUN_TIMEOUT   = 40000;
    localparam int DRAIN_TIMEOUT = 2000;

    logic              axi_aclk;
    logic              arst_n;
    logic              req_valid;
    logic [LEN_W-1:0]  req_len;
    logic              req_ready;
    logic              ar_valid;
    logic [LEN_W-1:0]  ar_len;
    logic              ar_ready;
    logic              r_valid;
    logic [RD_DW-1:0]  r_data;
    logic              out_valid;
    logic [RD_DW-1:0]  out_data;
    logic              out_ready;
    logic [BUF_CW-1:0] space_free;
    logic              alloc_full;
    logic              alloc_almost_full;

    // --------------------------------------------------
    // Model state
    // --------------------------------------------------

    // Accepted lengths not yet seen on the address channel
    int unsigned      len_q[$];
    // Returned beats not yet drained
    logic [RD_DW-1:0] data_q[$];
    int               resv;
    int               mem_beats;
    int               n_sent;
    int               n_acc;
    int               total_req;
    int               total_drained;
    int               errors;
    int               n_checks;
    int               cycles;
    bit               req_taken;

    stream_rd_buf i_stream_rd_buf (
        .axi_aclk          (axi_aclk),
        .arst_n            (arst_n),
        .req_valid         (req_valid),
        .req_len           (req_len),
        .req_ready         (req_ready),
        .ar_valid          (ar_valid),
        .ar_len            (ar_len),
        .ar_ready          (ar_ready),
        .r_valid           (r_valid),
        .r_data            (r_data),
        .out_valid         (out_valid),
        .out_data          (out_data),
        .out_ready         (out_ready),
        .space_free        (space_free),
        .alloc_full        (alloc_full),
        .alloc_almost_full (alloc_almost_full)
    );

    // 100 ns clock
    initial axi_aclk = 1'b0;
    always #50 axi_aclk = ~axi_aclk;

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        n_checks++;
        if (exp !== act) begin
            errors++;
            $display("ERROR %s expected 0x%0h actual 0x%0h", name, exp, act);
        end
    endtask

    // --------------------------------------------------
    // Stimulus applied on the falling edge
    // --------------------------------------------------

    task automatic drive_inputs(input bit drain_phase);
        // Request holds until taken
        if (!req_valid || req_taken) begin
            if (!drain_phase && n_sent < NUM_REQ && $urandom_range(0, 2) != 0) begin
                req_valid = 1'b1;
                req_len   = LEN_W'($urandom_range(1, MAX_BURST));
                n_sent++;
            end else begin
                req_valid = 1'b0;
                req_len   = '0;
            end
        end
        ar_ready  = drain_phase || ($urandom_range(0, 3) != 0);
        // Consumer mostly stalled so the buffer fills up
        out_ready = drain_phase || ($urandom_range(0, 3) == 0);
        // Memory sends owed beats with random gaps
        if (mem_beats > 0 && (drain_phase || $urandom_range(0, 2) != 0)) begin
            r_valid = 1'b1;
            r_data  = $urandom;
        end else begin
            r_valid = 1'b0;
            r_data  = '0;
        end
    endtask

    // --------------------------------------------------
    // Checks and model update just before the rising edge
    // --------------------------------------------------

    task automatic sample_outputs();
        int space;
        space = BUF_DEPTH - resv;
        check_value("space_free", space, space_free);
        check_value("alloc_full", space == 0, alloc_full);
        check_value("alloc_almost_full", space <= ALMOST_FULL_MARGIN, alloc_almost_full);
        // Slot free in the issue queue and the burst fits
        check_value("req_ready", len_q.size() < 2 && req_len <= space, req_ready);
        // Address transfers are for earlier acceptances
        if (ar_valid && ar_ready) begin
            if (len_q.size() == 0) begin
                errors++;
                $display("Address burst issued with no accepted request outstanding");
            end else begin
                check_value("ar_len", len_q.pop_front(), ar_len);
            end
            mem_beats += ar_len;
        end
        req_taken = req_valid && req_ready;
        if (req_taken) begin
            check_value("req_len_fits", 1, req_len <= space);
            len_q.push_back(req_len);
            resv      += req_len;
            total_req += req_len;
            n_acc++;
        end
        if (out_valid && out_ready) begin
            if (data_q.size() == 0) begin
                errors++;
                $display("Beat drained while no returned beat was outstanding");
            end else begin
                check_value("out_data", data_q.pop_front(), out_data);
            end
            resv--;
            total_drained++;
        end
        if (r_valid) begin
            data_q.push_back(r_data);
            mem_beats--;
        end
    endtask

    task automatic step_cycle(input bit drain_phase);
        @(negedge axi_aclk);
        drive_inputs(drain_phase);
        #40;
        sample_outputs();
    endtask

    // No burst, beat or owed data left on any channel
    function automatic bit design_idle();
        return !out_valid && !ar_valid && !r_valid
            && len_q.size() == 0 && mem_beats == 0;
    endfunction

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------

    initial begin
        void'($urandom(41));
        arst_n        = 1'b0;
        req_valid     = 1'b0;
        req_len       = '0;
        ar_ready      = 1'b0;
        r_valid       = 1'b0;
        r_data        = '0;
        out_ready     = 1'b0;
        resv          = 0;
        mem_beats     = 0;
        n_sent        = 0;
        n_acc         = 0;
        total_req     = 0;
        total_drained = 0;
        errors        = 0;
        n_checks      = 0;
        req_taken     = 1'b0;

        repeat (3) @(posedge axi_aclk);
        @(negedge axi_aclk);
        arst_n = 1'b1;
        #40;
        // State right out of reset
        check_value("ar_valid", 0, ar_valid);
        check_value("out_valid", 0, out_valid);
        check_value("req_ready", 1, req_ready);
        check_value("space_free", BUF_DEPTH, space_free);
        check_value("alloc_full", 0, alloc_full);

        // Random traffic until every request is accepted
        cycles = 0;
        while (n_acc < NUM_REQ && cycles < RUN_TIMEOUT) begin
            step_cycle(1'b0);
            cycles++;
        end
        if (n_acc < NUM_REQ) begin
            errors++;
            $display("Stall: only %0d of %0d requests accepted", n_acc, NUM_REQ);
        end else begin
            // Requests stopped and every channel flowing
            cycles = 0;
            while (!design_idle() && cycles < DRAIN_TIMEOUT) begin
                step_cycle(1'b1);
                cycles++;
            end
            if (!design_idle()) begin
                errors++;
                $display("Stall: the design did not drain within %0d cycles", DRAIN_TIMEOUT);
            end else begin
                check_value("total_drained", total_req, total_drained);
                check_value("space_free", BUF_DEPTH, space_free);
            end
        end

        $display("Checks run: %0d, errors: %0d", n_checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule : tb_stream_rd_buf

// File: hdl/alloc_ctrl.sv
// Allocation stage
// Virtual FIFO without storage: reserves a whole burst per request,
// gives back one entry per drained beat

`timescale 1ns/10ps

module alloc_ctrl (
    input  logic                            axi_aclk,
    input  logic                            arst_n,
    // Request side
    input  logic                            req_valid,
    input  logic [axi_rd_pkg::LEN_W-1:0]    req_len,
    output logic                            req_ready,
    // Toward the issue queue
    input  logic                            issue_ready,
    output logic                            grant_valid,
    output logic [axi_rd_pkg::LEN_W-1:0]    grant_len,
    // From the data buffer drain
    input  logic                            beat_release,
    // Status
    output logic [buf_geom_pkg::BUF_CW-1:0] space_free,
    output logic                            alloc_full,
    output logic                            alloc_almost_full
);

    import buf_geom_pkg::*;
    import axi_rd_pkg::*;

    logic [BUF_CW:0]   alloc_ptr;
    logic [BUF_CW:0]   rel_ptr;
    logic [BUF_CW:0]   alloc_ptr_next;
    logic [BUF_CW:0]   rel_ptr_next;
    logic [BUF_CW-1:0] count;
    logic              rel_empty;
    logic              fits;

    // --------------------------------------------------
    // Request acceptance
    // --------------------------------------------------

    // Whole burst must fit in what is left
    assign fits = (LEN_W'(space_free) >= req_len);

    // Queue slot and room both needed
    assign req_ready   = issue_ready && fits;
    assign grant_valid = req_valid && req_ready;
    assign grant_len   = req_len;

    // --------------------------------------------------
    // Pointers
    // --------------------------------------------------

    // Jumps by the granted length
    assign alloc_ptr_next = alloc_ptr + (grant_valid ? (BUF_CW + 1)'(req_len) : '0);

    // One step per drained beat
    assign rel_ptr_next = rel_ptr + (BUF_CW + 1)'(beat_release);

    always_ff @(posedge axi_aclk or negedge arst_n) begin
        if (!arst_n) begin
            alloc_ptr <= '0;
            rel_ptr   <= '0;
        end else begin
            alloc_ptr <= alloc_ptr_next;
            rel_ptr   <= rel_ptr_next;
        end
    end

    // Flags see next-state pointers so they land right after the edge
    alloc_flags i_alloc_flags (
        .axi_aclk       (axi_aclk),
        .arst_n         (arst_n),
        .alloc_ptr_next (alloc_ptr_next),
        .rel_ptr_next   (rel_ptr_next),
        .count          (count),
        .full           (alloc_full),
        .almost_full    (alloc_almost_full),
        .empty          (rel_empty),
        .almost_empty   ()
    );

    // Free entries
    assign space_free = BUF_CW'(BUF_DEPTH) - count;

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------

    // A drained beat always has a reservation behind it
    a_release_not_empty : assert property (
        @(posedge axi_aclk) disable iff (!arst_n)
        beat_release |-> !rel_empty
    );

    // Burst lengths stay legal
    a_req_len_range : assert property (
        @(posedge axi_aclk) disable iff (!arst_n)
        grant_valid |-> (req_len >= LEN_W'(1)) && (req_len <= LEN_W'(MAX_BURST))
    );

endmodule : alloc_ctrl

// File: hdl/alloc_flags.sv
// Allocation flag block
// Occupancy and registered full/empty flags from the
// next-state allocation and release pointers

`timescale 1ns/10ps

module alloc_flags (
    input  logic                            axi_aclk,
    input  logic                            arst_n,
    input  logic [buf_geom_pkg::BUF_CW:0]   alloc_ptr_next,
    input  logic [buf_geom_pkg::BUF_CW:0]   rel_ptr_next,
    output logic [buf_geom_pkg::BUF_CW-1:0] count,
    output logic                            full,
    output logic                            almost_full,
    output logic                            empty,
    output logic                            almost_empty
);

    import buf_geom_pkg::*;

    // Occupancy after this edge
    logic [BUF_CW-1:0] count_next;

    // Pointer distance never exceeds depth, low bits are enough
    assign count_next = BUF_CW'(alloc_ptr_next - rel_ptr_next);

    // --------------------------------------------------
    // Registered count and flags
    // --------------------------------------------------

    always_ff @(posedge axi_aclk or negedge arst_n) begin
        if (!arst_n) begin
            count        <= '0;
            full         <= 1'b0;
            almost_full  <= 1'b0;
            // Nothing reserved out of reset
            empty        <= 1'b1;
            almost_empty <= 1'b1;
        end else begin
            count        <= count_next;
            // No free entry left
            full         <= (count_next == BUF_CW'(BUF_DEPTH));
            // Free space at or below the margin
            almost_full  <= (count_next >= BUF_CW'(BUF_DEPTH - ALMOST_FULL_MARGIN));
            // No outstanding reservation
            empty        <= (count_next == '0);
            almost_empty <= (count_next <= BUF_CW'(ALMOST_EMPTY_MARGIN));
        end
    end

endmodule : alloc_flags

// File: hdl/ar_issue.sv
// Address issue stage
// Two-entry queue of granted bursts driving the AR-style channel

`timescale 1ns/10ps

module ar_issue (
    input  logic                         axi_aclk,
    input  logic                         arst_n,
    // From the allocator
    input  logic                         grant_valid,
    input  logic [axi_rd_pkg::LEN_W-1:0] grant_len,
    output logic                         issue_ready,
    // Address channel
    output logic                         ar_valid,
    output logic [axi_rd_pkg::LEN_W-1:0] ar_len,
    input  logic                         ar_ready
);

    import axi_rd_pkg::*;

    // Burst lengths waiting for the address channel
    logic [LEN_W-1:0] slot_len [2];
    logic             wr_ptr;
    logic             rd_ptr;
    logic [1:0]       count;
    logic [1:0]       count_next;
    logic             push;
    logic             pop;

    // --------------------------------------------------
    // Queue control
    // --------------------------------------------------

    assign issue_ready = (count != 2'd2);
    assign push        = grant_valid && issue_ready;
    assign pop         = ar_valid && ar_ready;
    assign count_next  = count + 2'(push) - 2'(pop);

    always_ff @(posedge axi_aclk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr   <= 1'b0;
            rd_ptr   <= 1'b0;
            count    <= '0;
            ar_valid <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= !wr_ptr;
            end
            if (pop) begin
                rd_ptr <= !rd_ptr;
            end
            count    <= count_next;
            // Valid whenever a burst is left after this edge
            ar_valid <= (count_next != 2'd0);
        end
    end

    // Length slots
    always_ff @(posedge axi_aclk) begin
        if (push) begin
            slot_len[wr_ptr] <= grant_len;
        end
    end

    // Oldest burst first
    assign ar_len = slot_len[rd_ptr];

    // Held burst may not change under back-pressure
    a_ar_stable : assert property (
        @(posedge axi_aclk) disable iff (!arst_n)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar_len)
    );

endmodule : ar_issue

// File: hdl/axi_rd_pkg.sv
// Read channel package
// Data width and burst length encoding of the read path

package axi_rd_pkg;

    // --------------------------------------------------
    // Data path
    // --------------------------------------------------

    // Beat width
    localparam int RD_DW = 32;

    // --------------------------------------------------
    // Burst length
    // --------------------------------------------------

    // Length field carries beat count, not count minus one
    localparam int LEN_W = 8;

    // Longest burst a requester may ask for
    localparam int MAX_BURST = 16;

endpackage : axi_rd_pkg

// File: hdl/buf_geom_pkg.sv
// Buffer geometry package
// Depth, pointer and count widths, almost margins
// Shared by the allocator and the data buffer

package buf_geom_pkg;

    // --------------------------------------------------
    // Storage size
    // --------------------------------------------------

    // Entries in the data buffer
    localparam int BUF_DEPTH = 64;

    // Entry address width
    localparam int BUF_AW = $clog2(BUF_DEPTH);

    // Count width, one bit more so a full buffer fits
    localparam int BUF_CW = BUF_AW + 1;

    // --------------------------------------------------
    // Flag margins
    // --------------------------------------------------

    // Almost full once free space drops to this
    localparam int ALMOST_FULL_MARGIN = 4;

    // Almost empty at or below this many reservations
    localparam int ALMOST_EMPTY_MARGIN = 4;

endpackage : buf_geom_pkg

// File: hdl/rd_data_buf.sv
// Read data buffer
// Stores returning beats and presents the oldest on a fall-through
// drain port; each drain gives one reservation back

`timescale 1ns/10ps

module rd_data_buf (
    input  logic                         axi_aclk,
    input  logic                         arst_n,
    // Read data from memory, never stalled
    input  logic                         r_valid,
    input  logic [axi_rd_pkg::RD_DW-1:0] r_data,
    // Drain port
    output logic                         out_valid,
    output logic [axi_rd_pkg::RD_DW-1:0] out_data,
    input  logic                         out_ready,
    // Back to the allocator
    output logic                         beat_release
);

    import buf_geom_pkg::*;
    import axi_rd_pkg::*;

    logic [RD_DW-1:0]  mem [BUF_DEPTH];
    logic [BUF_AW-1:0] wr_ptr;
    logic [BUF_AW-1:0] rd_ptr;
    logic [BUF_CW-1:0] count;
    logic              drain;

    // --------------------------------------------------
    // Drain side
    // --------------------------------------------------

    assign out_valid    = (count != '0);
    assign drain        = out_valid && out_ready;
    // Release is the drain transfer itself
    assign beat_release = drain;

    // Head entry straight out
    assign out_data = mem[rd_ptr];

    // --------------------------------------------------
    // Pointers and count
    // --------------------------------------------------

    always_ff @(posedge axi_aclk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Power-of-two depth, pointers wrap on their own
            if (r_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (drain) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + BUF_CW'(r_valid) - BUF_CW'(drain);
        end
    end

    // Beat storage
    always_ff @(posedge axi_aclk) begin
        if (r_valid) begin
            mem[wr_ptr] <= r_data;
        end
    end

    // Reservation upstream keeps room for every returning beat
    a_no_write_when_full : assert property (
        @(posedge axi_aclk) disable iff (!arst_n)
        r_valid |-> (count != BUF_CW'(BUF_DEPTH))
    );

endmodule : rd_data_buf

// File: hdl/stream_rd_buf.sv
// Pre-allocating read-stream buffer
// Allocation, address issue and data buffer stages in a row

`timescale 1ns/10ps

module stream_rd_buf (
    input  logic                            axi_aclk,
    input  logic                            arst_n,
    // Request channel
    input  logic                            req_valid,
    input  logic [axi_rd_pkg::LEN_W-1:0]    req_len,
    output logic                            req_ready,
    // Address channel
    output logic                            ar_valid,
    output logic [axi_rd_pkg::LEN_W-1:0]    ar_len,
    input  logic                            ar_ready,
    // Read data channel
    input  logic                            r_valid,
    input  logic [axi_rd_pkg::RD_DW-1:0]    r_data,
    // Drain channel
    output logic                            out_valid,
    output logic [axi_rd_pkg::RD_DW-1:0]    out_data,
    input  logic                            out_ready,
    // Status
    output logic [buf_geom_pkg::BUF_CW-1:0] space_free,
    output logic                            alloc_full,
    output logic                            alloc_almost_full
);

    import axi_rd_pkg::*;

    // Stage to stage
    logic             grant_valid;
    logic [LEN_W-1:0] grant_len;
    logic             issue_ready;
    logic             beat_release;

    alloc_ctrl i_alloc_ctrl (
        .axi_aclk          (axi_aclk),
        .arst_n            (arst_n),
        .req_valid         (req_valid),
        .req_len           (req_len),
        .req_ready         (req_ready),
        .issue_ready       (issue_ready),
        .grant_valid       (grant_valid),
        .grant_len         (grant_len),
        .beat_release      (beat_release),
        .space_free        (space_free),
        .alloc_full        (alloc_full),
        .alloc_almost_full (alloc_almost_full)
    );

    ar_issue i_ar_issue (
        .axi_aclk    (axi_aclk),
        .arst_n      (arst_n),
        .grant_valid (grant_valid),
        .grant_len   (grant_len),
        .issue_ready (issue_ready),
        .ar_valid    (ar_valid),
        .ar_len      (ar_len),
        .ar_ready    (ar_ready)
    );

    rd_data_buf i_rd_data_buf (
        .axi_aclk     (axi_aclk),
        .arst_n       (arst_n),
        .r_valid      (r_valid),
        .r_data       (r_data),
        .out_valid    (out_valid),
        .out_data     (out_data),
        .out_ready    (out_ready),
        .beat_release (beat_release)
    );

endmodule : stream_rd_buf

// File: stream_rd_buf.f
hdl/buf_geom_pkg.sv
hdl/axi_rd_pkg.sv
hdl/alloc_flags.sv
hdl/alloc_ctrl.sv
hdl/ar_issue.sv
hdl/rd_data_buf.sv
hdl/stream_rd_buf.sv
bench/tb_stream_rd_buf.sv
